//--- dv/av_checker.sv
`timescale 1ns/100ps
`default_nettype none

module av_checker (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               tft_en,
	input  logic               audio_en,
	input  audio_pkg::sample_t step,
	input  tft_pkg::tft_out_t  tft,
	input  logic               aout,
	output int                 frames,
	output int                 runs,
	output int                 colour_errs,
	output int                 geom_errs,
	output int                 idle_errs,
	output int                 audio_errs
);
	import tft_pkg::*;
	import audio_pkg::*;

	tft_out_t prev;
	logic     tft_en_q;
	logic     in_frame;
	logic     restart;
	int       x;
	int       y;
	int       lines;
	int       hsyncs;
	logic     en_q;
	logic     aout_q;
	logic     started;
	sample_t  acc;
	int       high_len;
	int       low_len;
	int       low_limit;

	// Border colours, then the two gradients
	function automatic logic [23:0] pattern_colour(input int px, input int py);
		logic [23:0] colour;
		if (px == 0) begin
			colour = 24'hff0000;
		end else if (px == H_ACTIVE - 1) begin
			colour = 24'h00ff00;
		end else if (py == 0) begin
			colour = 24'h0000ff;
		end else if (py == V_ACTIVE - 1) begin
			colour = 24'hffff00;
		end else if (px[8]) begin
			colour = {8'h00, py[7:0], px[7:0]};
		end else begin
			colour = {px[7:0], py[7:0], 8'h00};
		end
		return colour;
	endfunction

	// Samples until the sawtooth gives a nonzero value
	function automatic int steps_to_nonzero(input sample_t from, input sample_t inc);
		int      n;
		sample_t v;
		n = 1;
		v = from + inc;
		while (v == '0 && n < PWM_PERIOD) begin
			n++;
			v = v + inc;
		end
		return n;
	endfunction

	// Video side
	always @(posedge clk) begin
		// Panel enable comes out one register later
		if (arst_n && tft.disp !== tft_en_q) begin
			idle_errs++;
			$display("error tft.disp: expected %h, got %h", tft_en_q, tft.disp);
		end
		if (!arst_n || !tft.disp) begin
			if (arst_n && !prev.disp && (tft.de || tft.hsync || tft.vsync)) begin
				idle_errs++;
				$display("error tft idle controls: expected 0, got de=%h hsync=%h vsync=%h",
					tft.de, tft.hsync, tft.vsync);
			end
			in_frame = 1'b0;
			restart  = 1'b0;
		end else begin
			if (restart && !tft.vsync) begin
				idle_errs++;
				$display("display did not restart at a frame start after enable");
			end
			restart = !prev.disp;
			if (tft.vsync && !prev.vsync) begin
				if (in_frame) begin
					if (hsyncs != V_TOTAL) begin
						geom_errs++;
						$display("error tft.hsync pulses per frame: expected %0h, got %0h",
							V_TOTAL, hsyncs);
					end
					if (lines != V_ACTIVE) begin
						geom_errs++;
						$display("error tft.de lines per frame: expected %0h, got %0h",
							V_ACTIVE, lines);
					end
					frames++;
				end
				in_frame = 1'b1;
				x        = 0;
				y        = 0;
				lines    = 0;
				hsyncs   = 0;
			end
			if (tft.hsync && !prev.hsync) begin
				hsyncs++;
			end
			if (in_frame && tft.de) begin
				if (tft.rgb !== pattern_colour(x, y)) begin
					colour_errs++;
					$display("error tft.rgb at x=%0d y=%0d: expected %h, got %h",
						x, y, pattern_colour(x, y), tft.rgb);
				end
				x++;
			end
			// End of a visible line
			if (in_frame && !tft.de && prev.de) begin
				if (x != H_ACTIVE) begin
					geom_errs++;
					$display("error tft.de pixels in line %0d: expected %0h, got %0h",
						y, H_ACTIVE, x);
				end
				lines++;
				y++;
				x = 0;
			end
		end
		prev     = tft;
		tft_en_q = tft_en;
	end

	// Audio side, one high run per nonzero sample
	always @(posedge clk) begin
		if (!arst_n || !audio_en) begin
			if (arst_n && !en_q && aout) begin
				audio_errs++;
				$display("error aout while disabled: expected 0, got %h", aout);
			end
			acc       = '0;
			started   = 1'b0;
			high_len  = 0;
			low_len   = 0;
			low_limit = PWM_PERIOD;
		end else if (aout) begin
			if (!aout_q) begin
				if (started && low_len > low_limit) begin
					audio_errs++;
					$display("audio stall: aout stayed low for %0d cycles", low_len);
				end
				started  = 1'b1;
				high_len = 0;
			end
			high_len++;
		end else begin
			if (aout_q) begin
				acc = sample_t'(acc + steps_to_nonzero(acc, step) * step);
				if (high_len != int'(acc)) begin
					audio_errs++;
					$display("error aout high run %0d: expected %0h, got %0h",
						runs, acc, high_len);
				end
				runs++;
				// Zero samples add whole silent periods
				low_limit = PWM_PERIOD * steps_to_nonzero(acc, step);
				low_len   = 0;
			end
			low_len++;
		end
		en_q   = audio_en;
		aout_q = aout;
	end

endmodule

`default_nettype wire

//--- dv/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_top;
	import tft_pkg::*;
	import audio_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int LIMIT_CYCLES = 2 * FRAME_CYCLES + 300 * PWM_PERIOD + 20000;

	logic        clk;
	logic        arst_n;
	logic        tft_en;
	logic        audio_en;
	sample_t     step;
	tft_out_t    tft;
	logic        aout;
	logic [31:0] seed;
	int          frames;
	int          runs;
	int          colour_errs;
	int          geom_errs;
	int          idle_errs;
	int          audio_errs;
	int          tests;
	int          failed;
	int          base;
	int          target;
	int          total;

	av_top dut0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.tft_en   (tft_en),
		.audio_en (audio_en),
		.step     (step),
		.tft      (tft),
		.aout     (aout)
	);

	av_checker mon0 (
		.clk         (clk),
		.arst_n      (arst_n),
		.tft_en      (tft_en),
		.audio_en    (audio_en),
		.step        (step),
		.tft         (tft),
		.aout        (aout),
		.frames      (frames),
		.runs        (runs),
		.colour_errs (colour_errs),
		.geom_errs   (geom_errs),
		.idle_errs   (idle_errs),
		.audio_errs  (audio_errs)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Nonzero step, only while audio is off
	task automatic choose_step();
		seed = lcg_next(seed);
		while (seed[23:16] == 8'h00) begin
			seed = lcg_next(seed);
		end
		step = seed[23:16];
	endtask

	task automatic idle_random(input int base_cycles);
		seed = lcg_next(seed);
		repeat (base_cycles + int'(seed[25:18])) @(negedge clk);
	endtask

	function automatic int video_errs();
		return colour_errs + geom_errs + idle_errs;
	endfunction

	task automatic report_test(input string name, input int errs);
		tests++;
		if (errs != 0) begin
			failed++;
			$display("test %0d %s: failed with %0d errors", tests, name, errs);
		end else begin
			$display("test %0d %s: passed", tests, name);
		end
	endtask

	initial begin
		clk      = 1'b0;
		arst_n   = 1'b0;
		tft_en   = 1'b0;
		audio_en = 1'b0;
		step     = '0;
		seed     = 32'ha9a4_160d;
		tests    = 0;
		failed   = 0;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;

		// One full frame for the colour and geometry checks
		@(negedge clk);
		tft_en = 1'b1;
		wait (frames >= 1);
		report_test("colour pattern", colour_errs);
		report_test("frame geometry", geom_errs);

		// Panel off for a while, then a fresh frame
		base = video_errs();
		@(negedge clk);
		tft_en = 1'b0;
		idle_random(16);
		tft_en = 1'b1;
		target = frames + 1;
		wait (frames >= target);
		report_test("display disable", video_errs() - base);

		base = audio_errs;
		@(negedge clk);
		choose_step();
		audio_en = 1'b1;
		target   = runs + 64;
		wait (runs >= target);
		report_test("audio sawtooth", audio_errs - base);

		// Restart with a new step after a flush
		base = audio_errs;
		@(negedge clk);
		audio_en = 1'b0;
		idle_random(16);
		choose_step();
		audio_en = 1'b1;
		target   = runs + 16;
		wait (runs >= target);
		report_test("audio restart", audio_errs - base);

		total = video_errs() + audio_errs;
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			tests, tests - failed, failed, total);
		if (failed == 0 && total == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Two frames plus the audio periods, with some slack
	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles before the tests finished", LIMIT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/apu_pwm.sv
`timescale 1ns/100ps
`default_nettype none

module apu_pwm (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               audio_en,
	input  logic               empty,
	input  audio_pkg::sample_t rdata,
	output logic               pop,
	output logic               aout
);
	import audio_pkg::*;

	sample_t cnt;
	sample_t cmp;
	logic    period_end;

	assign period_end = cnt == SAMPLE_W'(PWM_PERIOD - 1);

	// Take the next sample in the last cycle of the period
	assign pop = audio_en && period_end && !empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt  <= '0;
			cmp  <= '0;
			aout <= 1'b0;
		end else if (!audio_en) begin
			cnt  <= '0;
			cmp  <= '0;
			aout <= 1'b0;
		end else begin
			cnt  <= cnt + 1'b1;
			aout <= cnt < cmp;
			// Empty buffer keeps the previous duty cycle
			if (pop) begin
				cmp <= rdata;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/audio_pkg.sv
`default_nettype none

package audio_pkg;

	// Sample resolution
	localparam int SAMPLE_W = 8;

	typedef logic [SAMPLE_W-1:0] sample_t;

	// Sample buffer
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AW    = 3;

	// One PWM period covers every sample value
	localparam int PWM_PERIOD = 2 ** SAMPLE_W;

endpackage

`default_nettype wire

//--- hdl/av_top.sv
`timescale 1ns/100ps
`default_nettype none

module av_top (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               tft_en,
	input  logic               audio_en,
	input  audio_pkg::sample_t step,
	output tft_pkg::tft_out_t  tft,
	output logic               aout
);
	import tft_pkg::*;
	import audio_pkg::*;

	// Video chain
	tft_pos_t pos;

	// Audio chain
	logic    push;
	logic    full;
	logic    pop;
	logic    empty;
	sample_t wdata;
	sample_t rdata;

	tft_timing timing0 (
		.clk    (clk),
		.arst_n (arst_n),
		.tft_en (tft_en),
		.pos    (pos)
	);

	tft_pattern pattern0 (
		.clk    (clk),
		.arst_n (arst_n),
		.tft_en (tft_en),
		.pos    (pos),
		.tft    (tft)
	);

	tone_gen tone0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.audio_en (audio_en),
		.step     (step),
		.full     (full),
		.push     (push),
		.wdata    (wdata)
	);

	sample_fifo fifo0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.audio_en (audio_en),
		.push     (push),
		.wdata    (wdata),
		.full     (full),
		.pop      (pop),
		.empty    (empty),
		.rdata    (rdata)
	);

	apu_pwm pwm0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.audio_en (audio_en),
		.empty    (empty),
		.rdata    (rdata),
		.pop      (pop),
		.aout     (aout)
	);

endmodule

`default_nettype wire

//--- hdl/sample_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sample_fifo (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               audio_en,
	input  logic               push,
	input  audio_pkg::sample_t wdata,
	output logic               full,
	input  logic               pop,
	output logic               empty,
	output audio_pkg::sample_t rdata
);
	import audio_pkg::*;

	sample_t            mem [FIFO_DEPTH];
	logic [FIFO_AW:0]   wr_ptr;
	logic [FIFO_AW:0]   rd_ptr;
	logic               wr_ok;
	logic               rd_ok;

	// Extra pointer bit tells full from empty
	assign empty = wr_ptr == rd_ptr;
	assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
		(wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

	assign wr_ok = audio_en && push && !full;
	assign rd_ok = audio_en && pop && !empty;

	// Head of the queue is always on rdata
	assign rdata = mem[rd_ptr[FIFO_AW-1:0]];

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr[FIFO_AW-1:0]] <= wdata;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (!audio_en) begin
			// Flush
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/tft_pattern.sv
`timescale 1ns/100ps
`default_nettype none

module tft_pattern (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              tft_en,
	input  tft_pkg::tft_pos_t pos,
	output tft_pkg::tft_out_t tft
);
	import tft_pkg::*;

	logic [23:0] colour;

	// Border colours first, gradient inside
	always_comb begin
		colour = '0;
		if (pos.de) begin
			if (pos.x == '0) begin
				colour = 24'hff0000;
			end else if (pos.x == COORD_W'(H_ACTIVE - 1)) begin
				colour = 24'h00ff00;
			end else if (pos.y == '0) begin
				colour = 24'h0000ff;
			end else if (pos.y == COORD_W'(V_ACTIVE - 1)) begin
				colour = 24'hffff00;
			end else if (pos.x[8]) begin
				colour = {8'h00, pos.y[7:0], pos.x[7:0]};
			end else begin
				colour = {pos.x[7:0], pos.y[7:0], 8'h00};
			end
		end
	end

	// Colour and controls leave on the same edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tft <= '0;
		end else begin
			tft.rgb   <= colour;
			tft.de    <= pos.de;
			tft.hsync <= pos.hsync;
			tft.vsync <= pos.vsync;
			tft.disp  <= tft_en;
		end
	end

endmodule

`default_nettype wire

//--- hdl/tft_pkg.sv
`default_nettype none

package tft_pkg;

	// Visible area
	localparam int H_ACTIVE = 480;
	localparam int V_ACTIVE = 272;

	// Porches and sync widths
	localparam int H_BACK  = 40;
	localparam int V_BACK  = 10;
	localparam int H_SYNC  = 1;
	localparam int V_SYNC  = 1;
	localparam int H_FRONT = 1;
	localparam int V_FRONT = 1;

	// Full line and frame lengths
	localparam int H_TOTAL = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
	localparam int V_TOTAL = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;

	// First active pixel and line, counted from the sync start
	localparam int H_START = H_SYNC + H_BACK;
	localparam int V_START = V_SYNC + V_BACK;

	localparam int COORD_W = 9;

	// Scan position from the timing generator
	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
		logic               de;
		logic               hsync;
		logic               vsync;
	} tft_pos_t;

	// Panel outputs
	typedef struct packed {
		logic [23:0] rgb;
		logic        de;
		logic        hsync;
		logic        vsync;
		logic        disp;
	} tft_out_t;

endpackage

`default_nettype wire

//--- hdl/tft_timing.sv
`timescale 1ns/100ps
`default_nettype none

module tft_timing (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              tft_en,
	output tft_pkg::tft_pos_t pos
);
	import tft_pkg::*;

	logic [$clog2(H_TOTAL)-1:0] hcount;
	logic [$clog2(V_TOTAL)-1:0] vcount;
	logic                       h_last;
	logic                       v_last;
	logic                       h_active;
	logic                       v_active;
	tft_pos_t                   pos_next;

	assign h_last = hcount == H_TOTAL - 1;
	assign v_last = vcount == V_TOTAL - 1;

	// Sync first, then back porch, active and front porch
	assign h_active = (hcount >= H_START) && (hcount < H_START + H_ACTIVE);
	assign v_active = (vcount >= V_START) && (vcount < V_START + V_ACTIVE);

	always_comb begin
		pos_next       = '0;
		pos_next.hsync = hcount < H_SYNC;
		pos_next.vsync = vcount < V_SYNC;
		pos_next.de    = h_active && v_active;
		if (h_active && v_active) begin
			// Coordinates relative to the first visible pixel
			pos_next.x = COORD_W'(hcount - H_START);
			pos_next.y = COORD_W'(vcount - V_START);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hcount <= '0;
			vcount <= '0;
			pos    <= '0;
		end else if (!tft_en) begin
			// Panel off, hold at the frame start
			hcount <= '0;
			vcount <= '0;
			pos    <= '0;
		end else begin
			pos <= pos_next;
			if (h_last) begin
				hcount <= '0;
				if (v_last) begin
					vcount <= '0;
				end else begin
					vcount <= vcount + 1'b1;
				end
			end else begin
				hcount <= hcount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/tone_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tone_gen (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               audio_en,
	input  audio_pkg::sample_t step,
	input  logic               full,
	output logic               push,
	output audio_pkg::sample_t wdata
);
	import audio_pkg::*;

	sample_t acc;

	// Offer a new sample whenever the buffer has room
	assign push  = audio_en && !full;
	assign wdata = acc + step;

	// Accumulator wraps, giving the sawtooth
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else if (!audio_en) begin
			acc <= '0;
		end else if (push) begin
			acc <= wdata;
		end
	end

endmodule

`default_nettype wire

//--- tb.f
hdl/tft_pkg.sv
hdl/audio_pkg.sv
hdl/tft_timing.sv
hdl/tft_pattern.sv
hdl/tone_gen.sv
hdl/sample_fifo.sv
hdl/apu_pwm.sv
hdl/av_top.sv
dv/av_checker.sv
dv/tb_top.sv
